// ==== pagerank_pkg.sv ====
package pagerank_pkg;

	//////////////////////////////////////////////////////////////////////
	// data widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [23:0] vertex_id_t;
	typedef logic [31:0] edge_index_t;
	typedef logic [15:0] degree_t;
	typedef logic [31:0] addr_t;
	// unsigned fixed point rank or neighbour contribution
	typedef logic [31:0] rank_t;
	// fraction of 2^16
	typedef logic [15:0] damping_t;
	typedef logic [1:0]  cfg_addr_t;

	//////////////////////////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////////////////////////

	localparam cfg_addr_t REG_ENABLE    = 2'd0;
	localparam cfg_addr_t REG_RANK_BASE = 2'd1;
	localparam cfg_addr_t REG_DAMPING   = 2'd2;
	localparam cfg_addr_t REG_BASE_TERM = 2'd3;

	// default buffer sizing
	localparam int DEF_JOB_DEPTH  = 4;
	localparam int DEF_DATA_DEPTH = 8;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		NEXT
	} read_engine_state_t;

endpackage

// ==== fifo.sv ====
module fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             alfull,
	input  logic             pop,
	output logic             valid,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;

	assign full     = (count == CNT_W'(DEPTH));
	assign alfull   = (count >= CNT_W'(DEPTH - 1));
	assign empty    = (count == '0);
	assign valid    = !empty;
	// head entry shows without a pop
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// the producer has to respect full, the consumer has to respect valid
	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) !(push && full));
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) !(pop && empty));

endmodule

// ==== cu_config_regs.sv ====
module cu_config_regs (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   cfg_req,
	input  logic                   cfg_write,
	input  pagerank_pkg::cfg_addr_t cfg_addr,
	input  pagerank_pkg::rank_t    cfg_wdata,
	output logic                   cfg_ack,
	output pagerank_pkg::rank_t    cfg_rdata,
	output logic                   enable,
	output pagerank_pkg::addr_t    rank_base_addr,
	output pagerank_pkg::damping_t damping,
	output pagerank_pkg::rank_t    base_term
);

	import pagerank_pkg::*;

	logic  access;
	rank_t rd_mux;

	// new request seen while ack still low
	assign access = cfg_req && !cfg_ack;

	always_comb begin
		case (cfg_addr)
			REG_ENABLE:    rd_mux = rank_t'(enable);
			REG_RANK_BASE: rd_mux = rank_t'(rank_base_addr);
			REG_DAMPING:   rd_mux = rank_t'(damping);
			default:       rd_mux = base_term;
		endcase
	end

	// ack follows req one cycle late on both edges
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_ack        <= 1'b0;
			enable         <= 1'b0;
			rank_base_addr <= '0;
			damping        <= '0;
			base_term      <= '0;
		end else begin
			cfg_ack <= cfg_req;
			if (access && cfg_write) begin
				case (cfg_addr)
					REG_ENABLE:    enable         <= cfg_wdata[0];
					REG_RANK_BASE: rank_base_addr <= addr_t'(cfg_wdata);
					REG_DAMPING:   damping        <= cfg_wdata[15:0];
					default:       base_term      <= cfg_wdata;
				endcase
			end
		end
	end

	// read data held for the whole ack phase
	always_ff @(posedge clock) begin
		if (access && !cfg_write)
			cfg_rdata <= rd_mux;
	end

	a_ack_needs_req: assert property (@(posedge clock) disable iff (!rstn)
		$rose(cfg_ack) |-> cfg_req);

endmodule

// ==== edge_read_engine.sv ====
module edge_read_engine #(
	parameter int DATA_DEPTH = pagerank_pkg::DEF_DATA_DEPTH
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enable,
	input  logic                      job_valid,
	input  pagerank_pkg::edge_index_t job_edge_start,
	input  pagerank_pkg::degree_t     job_degree,
	input  pagerank_pkg::vertex_id_t  job_vertex,
	input  logic                      rd_cmd_ready,
	input  logic                      data_consumed,
	input  logic                      meta_full,
	output logic                      job_pop,
	output logic                      meta_push,
	output logic                      rd_cmd_valid,
	output pagerank_pkg::addr_t       rd_cmd_addr
);

	import pagerank_pkg::*;

	localparam int OUT_W = $clog2(DATA_DEPTH + 1);

	read_engine_state_t state;
	edge_index_t        edge_ptr;
	degree_t            remaining;
	logic [OUT_W-1:0]   outstanding;
	logic               issue;

	// job taken and its meta entry pushed in the same cycle
	assign job_pop      = (state == IDLE) && enable && job_valid && !meta_full;
	assign meta_push    = job_pop;
	// stall once the read data buffer could be filled
	assign rd_cmd_valid = (state == ISSUE) && (outstanding != OUT_W'(DATA_DEPTH));
	assign rd_cmd_addr  = addr_t'(edge_ptr);
	assign issue        = rd_cmd_valid && rd_cmd_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			remaining <= '0;
		end else begin
			case (state)
				IDLE: if (job_pop) begin
					remaining <= job_degree;
					state     <= (job_degree == '0) ? NEXT : ISSUE;
				end
				ISSUE: if (issue) begin
					remaining <= remaining - 1'b1;
					if (remaining == degree_t'(1))
						state <= NEXT;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (job_pop)
			edge_ptr <= job_edge_start;
		else if (issue)
			edge_ptr <= edge_ptr + 1'b1;
	end

	// reads in flight or parked in the data buffer
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else if (issue && !data_consumed)
			outstanding <= outstanding + 1'b1;
		else if (data_consumed && !issue)
			outstanding <= outstanding - 1'b1;
	end

	a_rd_hold: assert property (@(posedge clock) disable iff (!rstn)
		rd_cmd_valid && !rd_cmd_ready |=> rd_cmd_valid && $stable(rd_cmd_addr));
	// job buffer head must be a real entry when taken
	a_job_known: assert property (@(posedge clock) disable iff (!rstn)
		meta_push |-> !$isunknown({job_vertex, job_degree, job_edge_start}));

endmodule

// ==== rank_accumulator.sv ====
module rank_accumulator (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     meta_valid,
	input  pagerank_pkg::vertex_id_t meta_vertex,
	input  pagerank_pkg::degree_t    meta_degree,
	input  logic                     data_valid,
	input  pagerank_pkg::rank_t      data,
	input  pagerank_pkg::damping_t   damping,
	input  pagerank_pkg::rank_t      base_term,
	input  pagerank_pkg::addr_t      rank_base_addr,
	input  logic                     wr_cmd_ready,
	output logic                     meta_pop,
	output logic                     data_pop,
	output logic                     wr_cmd_valid,
	output pagerank_pkg::addr_t      wr_cmd_addr,
	output pagerank_pkg::rank_t      wr_cmd_data
);

	import pagerank_pkg::*;

	rank_t       sum;
	degree_t     taken;
	logic        wr_pending;
	logic        collecting;
	logic        sum_done;
	logic        wr_fire;
	logic [47:0] scaled;
	rank_t       new_rank;

	//////////////////////////////////////////////////////////////////////
	// sum the head job's contributions
	//////////////////////////////////////////////////////////////////////

	assign collecting = meta_valid && !wr_pending;
	assign data_pop   = collecting && (taken != meta_degree) && data_valid;
	// all words in, also true at once for degree 0
	assign sum_done   = collecting && (taken == meta_degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum        <= '0;
			taken      <= '0;
			wr_pending <= 1'b0;
		end else begin
			if (wr_fire) begin
				sum        <= '0;
				taken      <= '0;
				wr_pending <= 1'b0;
			end else begin
				if (data_pop) begin
					// wraps at 32 bits
					sum   <= sum + data;
					taken <= taken + 1'b1;
				end
				if (sum_done)
					wr_pending <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// damping, base term and write command
	//////////////////////////////////////////////////////////////////////

	assign scaled   = 48'(sum) * 48'(damping);
	assign new_rank = base_term + rank_t'(scaled >> 16);

	always_ff @(posedge clock) begin
		if (sum_done) begin
			wr_cmd_addr <= rank_base_addr + addr_t'(meta_vertex);
			wr_cmd_data <= new_rank;
		end
	end

	assign wr_cmd_valid = wr_pending;
	assign wr_fire      = wr_cmd_valid && wr_cmd_ready;
	// meta entry retires with its write
	assign meta_pop     = wr_fire;

	a_wr_hold: assert property (@(posedge clock) disable iff (!rstn)
		wr_cmd_valid && !wr_cmd_ready |=>
			wr_cmd_valid && $stable(wr_cmd_addr) && $stable(wr_cmd_data));

endmodule

// ==== cu_vertex_pagerank.sv ====
module cu_vertex_pagerank #(
	parameter int JOB_DEPTH  = pagerank_pkg::DEF_JOB_DEPTH,
	parameter int DATA_DEPTH = pagerank_pkg::DEF_DATA_DEPTH
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enable,
	input  pagerank_pkg::addr_t       rank_base_addr,
	input  pagerank_pkg::damping_t    damping,
	input  pagerank_pkg::rank_t       base_term,
	input  logic                      job_valid,
	input  pagerank_pkg::vertex_id_t  job_vertex,
	input  pagerank_pkg::edge_index_t job_edge_start,
	input  pagerank_pkg::degree_t     job_degree,
	output logic                      job_request,
	output logic                      rd_cmd_valid,
	output pagerank_pkg::addr_t       rd_cmd_addr,
	input  logic                      rd_cmd_ready,
	input  logic                      rd_data_valid,
	input  pagerank_pkg::rank_t       rd_data,
	output logic                      wr_cmd_valid,
	output pagerank_pkg::addr_t       wr_cmd_addr,
	output pagerank_pkg::rank_t       wr_cmd_data,
	input  logic                      wr_cmd_ready,
	input  logic                      wr_resp_valid,
	output pagerank_pkg::vertex_id_t  vertex_num_counter,
	output pagerank_pkg::vertex_id_t  vertices_done
);

	import pagerank_pkg::*;

	localparam int JOB_W  = $bits(vertex_id_t) + $bits(edge_index_t) + $bits(degree_t);
	localparam int META_W = $bits(vertex_id_t) + $bits(degree_t);

	logic              job_in_valid;
	vertex_id_t        job_in_vertex;
	edge_index_t       job_in_edge_start;
	degree_t           job_in_degree;
	logic              rd_in_valid;
	rank_t             rd_in_data;

	logic              job_alfull;
	logic              job_head_valid;
	logic [JOB_W-1:0]  job_head;
	vertex_id_t        job_head_vertex;
	edge_index_t       job_head_edge_start;
	degree_t           job_head_degree;
	logic              job_pop;

	logic              meta_push;
	logic              meta_full;
	logic              meta_pop;
	logic              meta_valid;
	logic [META_W-1:0] meta_head;
	vertex_id_t        meta_vertex;
	degree_t           meta_degree;

	logic              data_valid;
	rank_t             data_head;
	logic              data_pop;

	//////////////////////////////////////////////////////////////////////
	// boundary registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_in_valid <= 1'b0;
			rd_in_valid  <= 1'b0;
		end else begin
			job_in_valid <= job_valid;
			rd_in_valid  <= rd_data_valid;
		end
	end

	always_ff @(posedge clock) begin
		job_in_vertex     <= job_vertex;
		job_in_edge_start <= job_edge_start;
		job_in_degree     <= job_degree;
		rd_in_data        <= rd_data;
	end

	// one slot of margin for the job already in the input register
	assign job_request = enable && !job_alfull;

	// accepted jobs and completed writes
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_num_counter <= '0;
			vertices_done      <= '0;
		end else begin
			if (job_in_valid)
				vertex_num_counter <= vertex_num_counter + 1'b1;
			if (wr_resp_valid)
				vertices_done <= vertices_done + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// job, meta and read data buffers
	//////////////////////////////////////////////////////////////////////

	fifo #(
		.WIDTH(JOB_W),
		.DEPTH(JOB_DEPTH)
	) job_fifo_inst (
		.clock(clock),
		.rstn(rstn),
		.push(job_in_valid),
		.data_in({job_in_vertex, job_in_edge_start, job_in_degree}),
		.full(),
		.alfull(job_alfull),
		.pop(job_pop),
		.valid(job_head_valid),
		.data_out(job_head),
		.empty()
	);

	assign {job_head_vertex, job_head_edge_start, job_head_degree} = job_head;

	fifo #(
		.WIDTH(META_W),
		.DEPTH(JOB_DEPTH)
	) meta_fifo_inst (
		.clock(clock),
		.rstn(rstn),
		.push(meta_push),
		.data_in({job_head_vertex, job_head_degree}),
		.full(meta_full),
		.alfull(),
		.pop(meta_pop),
		.valid(meta_valid),
		.data_out(meta_head),
		.empty()
	);

	assign {meta_vertex, meta_degree} = meta_head;

	// sized by the outstanding read limit, so never overflows
	fifo #(
		.WIDTH($bits(rank_t)),
		.DEPTH(DATA_DEPTH)
	) data_fifo_inst (
		.clock(clock),
		.rstn(rstn),
		.push(rd_in_valid),
		.data_in(rd_in_data),
		.full(),
		.alfull(),
		.pop(data_pop),
		.valid(data_valid),
		.data_out(data_head),
		.empty()
	);

	//////////////////////////////////////////////////////////////////////
	// engines
	//////////////////////////////////////////////////////////////////////

	edge_read_engine #(
		.DATA_DEPTH(DATA_DEPTH)
	) edge_read_engine_inst (
		.clock(clock),
		.rstn(rstn),
		.enable(enable),
		.job_valid(job_head_valid),
		.job_edge_start(job_head_edge_start),
		.job_degree(job_head_degree),
		.job_vertex(job_head_vertex),
		.rd_cmd_ready(rd_cmd_ready),
		.data_consumed(data_pop),
		.meta_full(meta_full),
		.job_pop(job_pop),
		.meta_push(meta_push),
		.rd_cmd_valid(rd_cmd_valid),
		.rd_cmd_addr(rd_cmd_addr)
	);

	rank_accumulator rank_accumulator_inst (
		.clock(clock),
		.rstn(rstn),
		.meta_valid(meta_valid),
		.meta_vertex(meta_vertex),
		.meta_degree(meta_degree),
		.data_valid(data_valid),
		.data(data_head),
		.damping(damping),
		.base_term(base_term),
		.rank_base_addr(rank_base_addr),
		.wr_cmd_ready(wr_cmd_ready),
		.meta_pop(meta_pop),
		.data_pop(data_pop),
		.wr_cmd_valid(wr_cmd_valid),
		.wr_cmd_addr(wr_cmd_addr),
		.wr_cmd_data(wr_cmd_data)
	);

endmodule

// ==== pagerank_cu_top.sv ====
module pagerank_cu_top #(
	parameter int JOB_DEPTH  = pagerank_pkg::DEF_JOB_DEPTH,
	parameter int DATA_DEPTH = pagerank_pkg::DEF_DATA_DEPTH
) (
	input  logic                      clock,
	input  logic                      rstn,
	// configuration port
	input  logic                      cfg_req,
	input  logic                      cfg_write,
	input  pagerank_pkg::cfg_addr_t   cfg_addr,
	input  pagerank_pkg::rank_t       cfg_wdata,
	output logic                      cfg_ack,
	output pagerank_pkg::rank_t       cfg_rdata,
	// job source
	input  logic                      job_valid,
	input  pagerank_pkg::vertex_id_t  job_vertex,
	input  pagerank_pkg::edge_index_t job_edge_start,
	input  pagerank_pkg::degree_t     job_degree,
	output logic                      job_request,
	// memory side
	output logic                      rd_cmd_valid,
	output pagerank_pkg::addr_t       rd_cmd_addr,
	input  logic                      rd_cmd_ready,
	input  logic                      rd_data_valid,
	input  pagerank_pkg::rank_t       rd_data,
	output logic                      wr_cmd_valid,
	output pagerank_pkg::addr_t       wr_cmd_addr,
	output pagerank_pkg::rank_t       wr_cmd_data,
	input  logic                      wr_cmd_ready,
	input  logic                      wr_resp_valid,
	// status
	output pagerank_pkg::vertex_id_t  vertex_num_counter,
	output pagerank_pkg::vertex_id_t  vertices_done
);

	import pagerank_pkg::*;

	logic     enable;
	addr_t    rank_base_addr;
	damping_t damping;
	rank_t    base_term;

	cu_config_regs cu_config_regs_inst (
		.clock(clock),
		.rstn(rstn),
		.cfg_req(cfg_req),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack),
		.cfg_rdata(cfg_rdata),
		.enable(enable),
		.rank_base_addr(rank_base_addr),
		.damping(damping),
		.base_term(base_term)
	);

	cu_vertex_pagerank #(
		.JOB_DEPTH(JOB_DEPTH),
		.DATA_DEPTH(DATA_DEPTH)
	) cu_vertex_pagerank_inst (
		.clock(clock),
		.rstn(rstn),
		.enable(enable),
		.rank_base_addr(rank_base_addr),
		.damping(damping),
		.base_term(base_term),
		.job_valid(job_valid),
		.job_vertex(job_vertex),
		.job_edge_start(job_edge_start),
		.job_degree(job_degree),
		.job_request(job_request),
		.rd_cmd_valid(rd_cmd_valid),
		.rd_cmd_addr(rd_cmd_addr),
		.rd_cmd_ready(rd_cmd_ready),
		.rd_data_valid(rd_data_valid),
		.rd_data(rd_data),
		.wr_cmd_valid(wr_cmd_valid),
		.wr_cmd_addr(wr_cmd_addr),
		.wr_cmd_data(wr_cmd_data),
		.wr_cmd_ready(wr_cmd_ready),
		.wr_resp_valid(wr_resp_valid),
		.vertex_num_counter(vertex_num_counter),
		.vertices_done(vertices_done)
	);

endmodule

// ==== pagerank_cu_tb.sv ====
module pagerank_cu_tb;

	import pagerank_pkg::*;

	localparam int       JOB_DEPTH     = 4;
	localparam int       DATA_DEPTH    = 8;
	localparam int       NUM_JOBS      = 16;
	localparam int       TIMEOUT       = 5000;
	localparam addr_t    RANK_BASE     = 32'h0040_0000;
	localparam damping_t DAMPING_VAL   = 16'hd99a;
	localparam rank_t    BASE_TERM_VAL = 32'h0000_2666;

	logic        clock;
	logic        rstn;
	logic        cfg_req;
	logic        cfg_write;
	cfg_addr_t   cfg_addr;
	rank_t       cfg_wdata;
	logic        cfg_ack;
	rank_t       cfg_rdata;
	logic        job_valid;
	vertex_id_t  job_vertex;
	edge_index_t job_edge_start;
	degree_t     job_degree;
	logic        job_request;
	logic        rd_cmd_valid;
	addr_t       rd_cmd_addr;
	logic        rd_cmd_ready;
	logic        rd_data_valid;
	rank_t       rd_data;
	logic        wr_cmd_valid;
	addr_t       wr_cmd_addr;
	rank_t       wr_cmd_data;
	logic        wr_cmd_ready;
	logic        wr_resp_valid;
	vertex_id_t  vertex_num_counter;
	vertex_id_t  vertices_done;

	integer      seed = 32'h33f0_ca51;
	int          cfg_errors = 0;
	int          rd_errors = 0;
	int          wr_errors = 0;
	int          hold_errors = 0;
	int          protocol_errors = 0;
	int          counter_errors = 0;
	int          jobs_sent = 0;
	int          resp_sent = 0;
	bit          enable_off = 1'b0;

	vertex_id_t  job_vertex_list [NUM_JOBS];
	edge_index_t job_start_list [NUM_JOBS];
	degree_t     job_degree_list [NUM_JOBS];
	int          job_gap_list [NUM_JOBS];

	// expectations, oldest first
	addr_t       exp_rd_q [$];
	addr_t       exp_wr_addr_q [$];
	rank_t       exp_wr_data_q [$];

	pagerank_cu_top #(
		.JOB_DEPTH(JOB_DEPTH),
		.DATA_DEPTH(DATA_DEPTH)
	) pagerank_cu_top_inst (
		.clock(clock),
		.rstn(rstn),
		.cfg_req(cfg_req),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack),
		.cfg_rdata(cfg_rdata),
		.job_valid(job_valid),
		.job_vertex(job_vertex),
		.job_edge_start(job_edge_start),
		.job_degree(job_degree),
		.job_request(job_request),
		.rd_cmd_valid(rd_cmd_valid),
		.rd_cmd_addr(rd_cmd_addr),
		.rd_cmd_ready(rd_cmd_ready),
		.rd_data_valid(rd_data_valid),
		.rd_data(rd_data),
		.wr_cmd_valid(wr_cmd_valid),
		.wr_cmd_addr(wr_cmd_addr),
		.wr_cmd_data(wr_cmd_data),
		.wr_cmd_ready(wr_cmd_ready),
		.wr_resp_valid(wr_resp_valid),
		.vertex_num_counter(vertex_num_counter),
		.vertices_done(vertices_done)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// contents of the contribution array
	function automatic rank_t mem_word(input addr_t addr);
		return addr * 32'd40503 + 32'd1;
	endfunction

	function automatic rank_t damped_rank(input rank_t sum);
		logic [47:0] prod;
		prod = {16'h0, sum} * {32'h0, DAMPING_VAL};
		return BASE_TERM_VAL + prod[47:16];
	endfunction

	function automatic void make_jobs();
		for (int i = 0; i < NUM_JOBS; i++) begin
			job_vertex_list[i] = vertex_id_t'($random(seed));
			job_start_list[i]  = edge_index_t'($random(seed));
			job_degree_list[i] = degree_t'($unsigned($random(seed)) % 11);
			// first half back to back to fill the buffers
			job_gap_list[i]    = (i < NUM_JOBS / 2) ? 0 : int'($unsigned($random(seed)) % 4);
		end
		job_degree_list[2]  = '0;
		job_degree_list[5]  = 16'd10;
		job_degree_list[11] = '0;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// in-order checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_read(input addr_t addr);
		addr_t exp_addr;
		if (exp_rd_q.size() == 0) begin
			rd_errors++;
			$display("Error %0t: read command to %h with no read expected", $time, addr);
		end else begin
			exp_addr = exp_rd_q.pop_front();
			assert (addr == exp_addr) else begin
				rd_errors++;
				$display("Error %0t: read address %h, expected %h", $time, addr, exp_addr);
			end
		end
	endtask

	task automatic check_write(input addr_t addr, input rank_t data);
		addr_t exp_addr;
		rank_t exp_data;
		if (exp_wr_addr_q.size() == 0) begin
			wr_errors++;
			$display("Error %0t: write to %h with no write expected", $time, addr);
		end else begin
			exp_addr = exp_wr_addr_q.pop_front();
			exp_data = exp_wr_data_q.pop_front();
			assert (addr == exp_addr && data == exp_data) else begin
				wr_errors++;
				$display("Error %0t: write %h <= %h, expected %h <= %h",
					$time, addr, data, exp_addr, exp_data);
			end
		end
	endtask

	a_rd_hold: assert property (@(posedge clock) disable iff (!rstn)
		rd_cmd_valid && !rd_cmd_ready |=> rd_cmd_valid && $stable(rd_cmd_addr))
		else begin
			hold_errors++;
			$display("Error %0t: read command changed while rd_cmd_ready was low", $time);
		end

	a_wr_hold: assert property (@(posedge clock) disable iff (!rstn)
		wr_cmd_valid && !wr_cmd_ready |=>
			wr_cmd_valid && $stable(wr_cmd_addr) && $stable(wr_cmd_data))
		else begin
			hold_errors++;
			$display("Error %0t: write command changed while wr_cmd_ready was low", $time);
		end

	a_ack_rise: assert property (@(posedge clock) disable iff (!rstn)
		cfg_req && !cfg_ack |=> cfg_ack)
		else begin
			protocol_errors++;
			$display("Error %0t: cfg_ack late after cfg_req rose", $time);
		end

	a_ack_fall: assert property (@(posedge clock) disable iff (!rstn)
		!cfg_req && cfg_ack |=> !cfg_ack)
		else begin
			protocol_errors++;
			$display("Error %0t: cfg_ack late after cfg_req fell", $time);
		end

	a_no_request: assert property (@(posedge clock) disable iff (!rstn)
		enable_off |-> !job_request)
		else begin
			protocol_errors++;
			$display("Error %0t: job_request high while disabled", $time);
		end

	//////////////////////////////////////////////////////////////////////
	// memory responder
	//////////////////////////////////////////////////////////////////////

	initial begin
		int   cycle;
		int   due;
		int   last_due;
		logic rd_fire;
		logic wr_fire;
		logic resp_d1;
		addr_t ret_addr_q [$];
		int   ret_due_q [$];
		cycle         = 0;
		last_due      = 0;
		resp_d1       = 1'b0;
		rd_cmd_ready  = 1'b0;
		wr_cmd_ready  = 1'b0;
		rd_data_valid = 1'b0;
		rd_data       = '0;
		wr_resp_valid = 1'b0;
		forever begin
			@(posedge clock);
			cycle++;
			rd_fire = rstn && rd_cmd_valid && rd_cmd_ready;
			wr_fire = rstn && wr_cmd_valid && wr_cmd_ready;
			if (rd_fire) begin
				check_read(rd_cmd_addr);
				due = cycle + 1 + int'($unsigned($random(seed)) % 4);
				// data comes back in command order
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				ret_addr_q.push_back(rd_cmd_addr);
				ret_due_q.push_back(due);
			end
			if (wr_fire)
				check_write(wr_cmd_addr, wr_cmd_data);
			#1;
			rd_cmd_ready = ($random(seed) & 3) != 0;
			wr_cmd_ready = ($random(seed) & 1) != 0;
			if (ret_addr_q.size() > 0 && ret_due_q[0] <= cycle) begin
				rd_data_valid = 1'b1;
				rd_data       = mem_word(ret_addr_q.pop_front());
				void'(ret_due_q.pop_front());
			end else begin
				rd_data_valid = 1'b0;
			end
			wr_resp_valid = resp_d1;
			if (resp_d1)
				resp_sent++;
			resp_d1 = wr_fire;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// configuration driver and job source
	//////////////////////////////////////////////////////////////////////

	task automatic wait_ack(input logic level, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT; n++) begin
			@(posedge clock);
			if (cfg_ack == level) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			$display("Timeout: cfg_ack never went to %0b", level);
	endtask

	// four-phase access, entered and left just after a clock edge
	task automatic cfg_access(input logic write, input cfg_addr_t addr, input rank_t wdata,
			output rank_t rdata, output bit ok);
		cfg_write = write;
		cfg_addr  = addr;
		cfg_wdata = wdata;
		cfg_req   = 1'b1;
		wait_ack(1'b1, ok);
		rdata = cfg_rdata;
		if (!ok)
			return;
		#1;
		cfg_req = 1'b0;
		wait_ack(1'b0, ok);
		#1;
	endtask

	task automatic cfg_write_check(input cfg_addr_t addr, input rank_t value, output bit ok);
		rank_t rdata;
		cfg_access(1'b1, addr, value, rdata, ok);
		if (!ok)
			return;
		cfg_access(1'b0, addr, '0, rdata, ok);
		if (!ok)
			return;
		assert (rdata == value) else begin
			cfg_errors++;
			$display("Error %0t: register %0d reads %h, expected %h", $time, addr, rdata, value);
		end
	endtask

	task automatic send_job(input int idx, output bit ok);
		rank_t sum;
		addr_t addr;
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT; n++) begin
			@(posedge clock);
			if (job_request) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("Timeout: job_request stayed low before job %0d", idx);
			return;
		end
		#1;
		sum = '0;
		for (int e = 0; e < int'(job_degree_list[idx]); e++) begin
			addr = job_start_list[idx] + addr_t'(e);
			exp_rd_q.push_back(addr);
			sum = sum + mem_word(addr);
		end
		exp_wr_addr_q.push_back(RANK_BASE + addr_t'(job_vertex_list[idx]));
		exp_wr_data_q.push_back(damped_rank(sum));
		job_valid      = 1'b1;
		job_vertex     = job_vertex_list[idx];
		job_edge_start = job_start_list[idx];
		job_degree     = job_degree_list[idx];
		@(posedge clock);
		#1;
		job_valid = 1'b0;
		jobs_sent++;
		repeat (job_gap_list[idx]) @(posedge clock);
	endtask

	task automatic wait_drain(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT; n++) begin
			@(posedge clock);
			if (exp_wr_addr_q.size() == 0 && exp_rd_q.size() == 0 && resp_sent == jobs_sent) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			$display("Timeout: %0d writes still missing at the end", exp_wr_addr_q.size());
		#1;
	endtask

	task automatic run_sequence(output bit ok);
		cfg_write_check(REG_RANK_BASE, RANK_BASE, ok);
		if (!ok)
			return;
		cfg_write_check(REG_DAMPING, rank_t'(DAMPING_VAL), ok);
		if (!ok)
			return;
		cfg_write_check(REG_BASE_TERM, BASE_TERM_VAL, ok);
		if (!ok)
			return;
		cfg_write_check(REG_ENABLE, 32'h1, ok);
		if (!ok)
			return;
		for (int i = 0; i < NUM_JOBS; i++) begin
			send_job(i, ok);
			if (!ok)
				return;
		end
		wait_drain(ok);
		if (!ok)
			return;
		cfg_write_check(REG_ENABLE, 32'h0, ok);
		if (!ok)
			return;
		enable_off = 1'b1;
		// idle window for the job_request check
		repeat (8) @(posedge clock);
		assert (vertex_num_counter == vertex_id_t'(jobs_sent)) else begin
			counter_errors++;
			$display("Error %0t: vertex_num_counter %0d, expected %0d",
				$time, vertex_num_counter, jobs_sent);
		end
		assert (vertices_done == vertex_id_t'(resp_sent)) else begin
			counter_errors++;
			$display("Error %0t: vertices_done %0d, expected %0d", $time, vertices_done, resp_sent);
		end
	endtask

	initial begin
		bit ok;
		int total;
		rstn           = 1'b0;
		cfg_req        = 1'b0;
		cfg_write      = 1'b0;
		cfg_addr       = REG_ENABLE;
		cfg_wdata      = '0;
		job_valid      = 1'b0;
		job_vertex     = '0;
		job_edge_start = '0;
		job_degree     = '0;
		make_jobs();
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
		run_sequence(ok);
		total = cfg_errors + rd_errors + wr_errors + hold_errors + protocol_errors
			+ counter_errors;
		$display("errors: config %0d, read %0d, write %0d, hold %0d, protocol %0d, counters %0d",
			cfg_errors, rd_errors, wr_errors, hold_errors, protocol_errors, counter_errors);
		if (ok && total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== pagerank_cu.f ====
pagerank_pkg.sv
fifo.sv
cu_config_regs.sv
edge_read_engine.sv
rank_accumulator.sv
cu_vertex_pagerank.sv
pagerank_cu_top.sv
pagerank_cu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the PageRank compute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pagerank_cu.f \
	--top-module pagerank_cu_tb -o sim_pagerank_cu
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/sim_pagerank_cu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "$out" | grep -q "^STATUS: PASS$"
exit $?
